/* hdl/addr_map_pkg.sv */
/*
 * address map package
 * address width and type shared by the routing table, the decoder and the
 * request path, plus the opcode that selects which routing table field a
 * configuration write updates
 */

package addr_map_pkg;

  // width of request and rule addresses
  parameter int unsigned ADDR_W = 32;

  // one address, used for rule bounds and request addresses alike
  typedef logic [ADDR_W-1:0] addr_t;

  // bit of the config write data that carries the default-port enable
  parameter int unsigned DEFAULT_EN_BIT = 31;

  // field selector of a configuration write
  // start and end bound the rule window, end is exclusive
  // FIELD_PORT takes the target port from the low data bits
  // FIELD_DEFAULT ignores the rule index, the enable sits at DEFAULT_EN_BIT
  // and the default port in the low data bits
  typedef enum logic [1:0] {
    FIELD_START   = 2'd0,
    FIELD_END     = 2'd1,
    FIELD_PORT    = 2'd2,
    FIELD_DEFAULT = 2'd3
  } cfg_field_e;

endpackage : addr_map_pkg

/* hdl/route_pkg.sv */
/*
 * request path package
 * operation code and write data type carried from the request
 * input through the router to the target ports
 */

package route_pkg;

  // request operation, passed through to the selected port unchanged
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } req_op_e;

  // width of the write payload
  parameter int unsigned DATA_W = 32;

  // write payload, ignored by the router itself
  typedef logic [DATA_W-1:0] data_t;

endpackage : route_pkg

/* hdl/addr_map_regs.sv */
/*
 * address map registers
 * software-written routing table: per rule a start address, an end
 * address and a target port, plus one default port with its enable.
 * one field is written per config strobe, visible on the next cycle
 */

`timescale 1ns/1ps

module addr_map_regs #(
  parameter int unsigned NO_RULES = 4,
  parameter int unsigned NO_PORTS = 4,
  // index widths follow from the counts, kept at least one bit wide
  localparam int unsigned RULE_W = (NO_RULES > 1) ? $clog2(NO_RULES) : 1,
  localparam int unsigned PORT_W = (NO_PORTS > 1) ? $clog2(NO_PORTS) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  // config write strobe and its selectors
  input  logic                                   cfg_we_i,
  input  addr_map_pkg::cfg_field_e               cfg_field_i,
  input  logic [RULE_W-1:0]                      cfg_rule_i,
  input  addr_map_pkg::addr_t                    cfg_wdata_i,
  // flattened table towards the decoder, rule 0 in the low slice
  output logic [NO_RULES*addr_map_pkg::ADDR_W-1:0] rule_start_o,
  output logic [NO_RULES*addr_map_pkg::ADDR_W-1:0] rule_end_o,
  output logic [NO_RULES*PORT_W-1:0]             rule_port_o,
  output logic                                   default_en_o,
  output logic [PORT_W-1:0]                      default_port_o
);

  import addr_map_pkg::*;

  // rule storage
  addr_t             start_q [NO_RULES];
  addr_t             end_q   [NO_RULES];
  logic [PORT_W-1:0] port_q  [NO_RULES];

  // default route
  logic              default_en_q;
  logic [PORT_W-1:0] default_port_q;

  // rule index falls inside the table, matters when NO_RULES is not a power of two
  logic              rule_in_range;

  assign rule_in_range = (int'(cfg_rule_i) < NO_RULES);

  // all zero after reset: start == end means an empty window, so nothing matches
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NO_RULES; i++) begin
        start_q[i] <= '0;
        end_q[i]   <= '0;
        port_q[i]  <= '0;
      end
      default_en_q   <= 1'b0;
      default_port_q <= '0;
    end else if (cfg_we_i) begin
      case (cfg_field_i)
        FIELD_START: begin
          if (rule_in_range) start_q[cfg_rule_i] <= cfg_wdata_i;
        end
        FIELD_END: begin
          if (rule_in_range) end_q[cfg_rule_i] <= cfg_wdata_i;
        end
        FIELD_PORT: begin
          // upper data bits beyond the port index are dropped
          if (rule_in_range) port_q[cfg_rule_i] <= cfg_wdata_i[PORT_W-1:0];
        end
        FIELD_DEFAULT: begin
          // rule index plays no part here
          default_en_q   <= cfg_wdata_i[DEFAULT_EN_BIT];
          default_port_q <= cfg_wdata_i[PORT_W-1:0];
        end
      endcase
    end
  end

  // flatten the arrays for the decoder
  always_comb begin
    for (int i = 0; i < NO_RULES; i++) begin
      rule_start_o[i*ADDR_W +: ADDR_W] = start_q[i];
      rule_end_o[i*ADDR_W +: ADDR_W]   = end_q[i];
      rule_port_o[i*PORT_W +: PORT_W]  = port_q[i];
    end
  end

  assign default_en_o   = default_en_q;
  assign default_port_o = default_port_q;

endmodule : addr_map_regs

/* hdl/addr_decode.sv */
/*
 * address decoder
 * compares one address against every rule window [start, end)
 * the highest-index matching rule wins, unmapped addresses fall to the
 * default port when it is enabled and to a decode error otherwise
 */

`timescale 1ns/1ps

module addr_decode #(
  parameter int unsigned NO_RULES = 4,
  parameter int unsigned NO_PORTS = 4,
  localparam int unsigned PORT_W = (NO_PORTS > 1) ? $clog2(NO_PORTS) : 1
) (
  input  addr_map_pkg::addr_t                      addr_i,
  // flattened rule table, rule 0 in the low slice
  input  logic [NO_RULES*addr_map_pkg::ADDR_W-1:0] rule_start_i,
  input  logic [NO_RULES*addr_map_pkg::ADDR_W-1:0] rule_end_i,
  input  logic [NO_RULES*PORT_W-1:0]               rule_port_i,
  input  logic                                     default_en_i,
  input  logic [PORT_W-1:0]                        default_port_i,
  output logic [PORT_W-1:0]                        port_idx_o,
  // dec_valid_o: some rule matched
  // dec_error_o: nothing matched and no default route
  output logic                                     dec_valid_o,
  output logic                                     dec_error_o
);

  import addr_map_pkg::*;

  addr_t lo_bound;
  addr_t hi_bound;

  always_comb begin
    // fallback when no rule hits
    port_idx_o  = default_en_i ? default_port_i : '0;
    dec_valid_o = 1'b0;
    dec_error_o = ~default_en_i;
    lo_bound    = '0;
    hi_bound    = '0;
    // ascending scan, so a later hit overrides an earlier one
    for (int i = 0; i < NO_RULES; i++) begin
      lo_bound = rule_start_i[i*ADDR_W +: ADDR_W];
      hi_bound = rule_end_i[i*ADDR_W +: ADDR_W];
      if ((addr_i >= lo_bound) && (addr_i < hi_bound)) begin
        port_idx_o  = rule_port_i[i*PORT_W +: PORT_W];
        dec_valid_o = 1'b1;
        dec_error_o = 1'b0;
      end
    end
  end

endmodule : addr_decode

/* hdl/req_router.sv */
/*
 * request router
 * samples a request together with its decode result and, one cycle
 * later, raises a single port strobe or the error strobe. the registered
 * op, address and data are broadcast to all ports
 */

`timescale 1ns/1ps

module req_router #(
  parameter int unsigned NO_PORTS = 4,
  localparam int unsigned PORT_W = (NO_PORTS > 1) ? $clog2(NO_PORTS) : 1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // incoming request, single-cycle strobe
  input  logic                 req_valid_i,
  input  route_pkg::req_op_e   req_op_i,
  input  addr_map_pkg::addr_t  req_addr_i,
  input  route_pkg::data_t     req_wdata_i,
  // decode result for the current request address
  input  logic [PORT_W-1:0]    port_idx_i,
  input  logic                 dec_error_i,
  // port side, strobe bit picks the receiving port
  output logic [NO_PORTS-1:0]  port_valid_o,
  output route_pkg::req_op_e   port_op_o,
  output addr_map_pkg::addr_t  port_addr_o,
  output route_pkg::data_t     port_wdata_o,
  // decode error side
  output logic                 err_valid_o,
  output addr_map_pkg::addr_t  err_addr_o
);

  import addr_map_pkg::*;
  import route_pkg::*;

  // response qualifiers
  logic              valid_q;
  logic              error_q;

  // sampled request
  logic [PORT_W-1:0] idx_q;
  req_op_e           op_q;
  addr_t             addr_q;
  data_t             wdata_q;

  // decoded port select before gating
  logic [NO_PORTS-1:0] port_sel;

  // one response per request, exactly one cycle later
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
      error_q <= dec_error_i;
    end
  end

  // payload only moves with a request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      idx_q   <= port_idx_i;
      op_q    <= req_op_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
  end

  // index to one-hot
  always_comb begin
    for (int unsigned p = 0; p < NO_PORTS; p++) begin
      port_sel[p] = (idx_q == PORT_W'(p));
    end
  end

  assign port_valid_o = port_sel & {NO_PORTS{valid_q & ~error_q}};
  assign err_valid_o  = valid_q & error_q;

  assign port_op_o    = op_q;
  assign port_addr_o  = addr_q;
  assign port_wdata_o = wdata_q;
  assign err_addr_o   = addr_q;

endmodule : req_router

/* hdl/xbar_route_top.sv */
/*
 * crossbar routing stage top
 * ties the routing table registers, the address decoder and the
 * request router together and sets rule and port counts for all three
 */

`timescale 1ns/1ps

module xbar_route_top #(
  parameter int unsigned NO_RULES = 4,
  parameter int unsigned NO_PORTS = 4,
  localparam int unsigned RULE_W = (NO_RULES > 1) ? $clog2(NO_RULES) : 1,
  localparam int unsigned PORT_W = (NO_PORTS > 1) ? $clog2(NO_PORTS) : 1
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // configuration
  input  logic                     cfg_we_i,
  input  addr_map_pkg::cfg_field_e cfg_field_i,
  input  logic [RULE_W-1:0]        cfg_rule_i,
  input  addr_map_pkg::addr_t      cfg_wdata_i,
  // requests
  input  logic                     req_valid_i,
  input  route_pkg::req_op_e       req_op_i,
  input  addr_map_pkg::addr_t      req_addr_i,
  input  route_pkg::data_t         req_wdata_i,
  // routed requests
  output logic [NO_PORTS-1:0]      port_valid_o,
  output route_pkg::req_op_e       port_op_o,
  output addr_map_pkg::addr_t      port_addr_o,
  output route_pkg::data_t         port_wdata_o,
  // decode errors
  output logic                     err_valid_o,
  output addr_map_pkg::addr_t      err_addr_o
);

  import addr_map_pkg::*;

  // table towards the decoder
  logic [NO_RULES*ADDR_W-1:0] rule_start;
  logic [NO_RULES*ADDR_W-1:0] rule_end;
  logic [NO_RULES*PORT_W-1:0] rule_port;
  logic                       default_en;
  logic [PORT_W-1:0]          default_port;

  // decode result towards the router
  logic [PORT_W-1:0]          port_idx;
  logic                       dec_error;

  addr_map_regs #(
    .NO_RULES (NO_RULES),
    .NO_PORTS (NO_PORTS)
  ) i_addr_map_regs (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_field_i    (cfg_field_i),
    .cfg_rule_i     (cfg_rule_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .rule_start_o   (rule_start),
    .rule_end_o     (rule_end),
    .rule_port_o    (rule_port),
    .default_en_o   (default_en),
    .default_port_o (default_port)
  );

  // route follows dec_error alone
  // dec_valid_o only tells a rule hit apart from the default route
  addr_decode #(
    .NO_RULES (NO_RULES),
    .NO_PORTS (NO_PORTS)
  ) i_addr_decode (
    .addr_i         (req_addr_i),
    .rule_start_i   (rule_start),
    .rule_end_i     (rule_end),
    .rule_port_i    (rule_port),
    .default_en_i   (default_en),
    .default_port_i (default_port),
    .port_idx_o     (port_idx),
    .dec_valid_o    (),
    .dec_error_o    (dec_error)
  );

  req_router #(
    .NO_PORTS (NO_PORTS)
  ) i_req_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .port_idx_i   (port_idx),
    .dec_error_i  (dec_error),
    .port_valid_o (port_valid_o),
    .port_op_o    (port_op_o),
    .port_addr_o  (port_addr_o),
    .port_wdata_o (port_wdata_o),
    .err_valid_o  (err_valid_o),
    .err_addr_o   (err_addr_o)
  );

endmodule : xbar_route_top

/* tests/xbar_route_properties.sv */
/*
 * router output assertions
 * strobe rules of the request router: at most one port, never port and
 * error together, one response per request, quiet outputs in reset
 */

`timescale 1ns/1ps

module xbar_route_properties #(
  parameter int unsigned NO_PORTS = 4
) (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                req_valid_i,
  input logic [NO_PORTS-1:0] port_valid_o,
  input logic                err_valid_o
);

  a_port_onehot0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(port_valid_o))
    else $error("port_valid_o has more than one bit set");

  a_port_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !((|port_valid_o) && err_valid_o))
    else $error("port strobe and error strobe high together");

  // every sampled request answered on the next cycle, exactly once
  a_one_response: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |=> ($countones({port_valid_o, err_valid_o}) == 1))
    else $error("request not followed by exactly one response strobe");

  a_no_stray: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !req_valid_i |=> ((port_valid_o == '0) && !err_valid_o))
    else $error("response strobe without a request");

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> ((port_valid_o == '0) && !err_valid_o))
    else $error("router outputs active during reset");

endmodule : xbar_route_properties

bind req_router xbar_route_properties #(
  .NO_PORTS (NO_PORTS)
) i_router_props (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .req_valid_i  (req_valid_i),
  .port_valid_o (port_valid_o),
  .err_valid_o  (err_valid_o)
);

/* tests/tb_xbar_route.sv */
/*
 * crossbar routing stage testbench
 * table of config writes and requests applied one per cycle, each
 * response checked one cycle later, then an lfsr address phase checked
 * against a mirror of the routing table
 */

`timescale 1ns/1ps

module tb_xbar_route;

  import addr_map_pkg::*;
  import route_pkg::*;

  localparam int NO_RULES     = 4;
  localparam int NO_PORTS     = 4;
  localparam int RULE_W       = 2;
  localparam int PORT_W       = 2;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_REQS    = 40;

  // one table entry, neither flag set means an idle cycle
  typedef struct packed {
    logic              is_cfg;
    logic              is_req;
    cfg_field_e        field;
    logic [RULE_W-1:0] rule;
    addr_t             cfg_data;
    req_op_e           op;
    addr_t             addr;
    data_t             data;
    logic              exp_err;
    logic [PORT_W-1:0] exp_port;
  } step_t;

  logic                clk_i;
  logic                arst_n_i;
  logic                cfg_we_i;
  cfg_field_e          cfg_field_i;
  logic [RULE_W-1:0]   cfg_rule_i;
  addr_t               cfg_wdata_i;
  logic                req_valid_i;
  req_op_e             req_op_i;
  addr_t               req_addr_i;
  data_t               req_wdata_i;
  logic [NO_PORTS-1:0] port_valid_o;
  req_op_e             port_op_o;
  addr_t               port_addr_o;
  data_t               port_wdata_o;
  logic                err_valid_o;
  addr_t               err_addr_o;

  step_t steps [$];
  step_t prev_step;
  step_t rnd_step;
  int    cycle_cnt = 0;
  int    cycle_limit;
  logic [31:0] lfsr_q = 32'ha4a0d4ec;
  logic [31:0] pick_bit;
  logic [31:0] low_bits;
  logic [31:0] op_bit;
  logic [31:0] wdata_bits;
  addr_t       rnd_addr;

  // mirror of the routing table as seen by the decoder
  addr_t             mir_start [NO_RULES];
  addr_t             mir_end   [NO_RULES];
  logic [PORT_W-1:0] mir_port  [NO_RULES];
  logic              mir_def_en;
  logic [PORT_W-1:0] mir_def_port;

  xbar_route_top #(
    .NO_RULES (NO_RULES),
    .NO_PORTS (NO_PORTS)
  ) i_dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_field_i  (cfg_field_i),
    .cfg_rule_i   (cfg_rule_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .port_valid_o (port_valid_o),
    .port_op_o    (port_op_o),
    .port_addr_o  (port_addr_o),
    .port_wdata_o (port_wdata_o),
    .err_valid_o  (err_valid_o),
    .err_addr_o   (err_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // run limit, set once the table is built
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the test did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // 32 bit fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] val;
    val = '0;
    repeat (n) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // {error, port} for an address, highest matching rule first
  function automatic logic [PORT_W:0] route_model(input addr_t a);
    logic [PORT_W:0] result;
    logic            hit;
    result = mir_def_en ? {1'b0, mir_def_port} : {1'b1, {PORT_W{1'b0}}};
    hit    = 1'b0;
    for (int i = NO_RULES - 1; i >= 0; i--) begin
      if (!hit && (a >= mir_start[i]) && (a < mir_end[i])) begin
        result = {1'b0, mir_port[i]};
        hit    = 1'b1;
      end
    end
    return result;
  endfunction

  function automatic step_t make_cfg(input cfg_field_e f, input logic [RULE_W-1:0] r,
                                     input addr_t d);
    step_t s;
    s          = '0;
    s.is_cfg   = 1'b1;
    s.field    = f;
    s.rule     = r;
    s.cfg_data = d;
    return s;
  endfunction

  // payload derived from the address so every request carries distinct data
  function automatic step_t make_req(input req_op_e op, input addr_t a, input logic err,
                                     input logic [PORT_W-1:0] p);
    step_t s;
    s          = '0;
    s.is_req   = 1'b1;
    s.op       = op;
    s.addr     = a;
    s.data     = a ^ 32'h5a5a_c3c3;
    s.exp_err  = err;
    s.exp_port = p;
    return s;
  endfunction

  task automatic update_mirror(input step_t s);
    case (s.field)
      FIELD_START: mir_start[s.rule] = s.cfg_data;
      FIELD_END:   mir_end[s.rule]   = s.cfg_data;
      FIELD_PORT:  mir_port[s.rule]  = s.cfg_data[PORT_W-1:0];
      FIELD_DEFAULT: begin
        mir_def_en   = s.cfg_data[31];
        mir_def_port = s.cfg_data[PORT_W-1:0];
      end
    endcase
  endtask

  // response to the entry driven one cycle earlier
  task automatic check_response(input step_t s);
    logic [NO_PORTS-1:0] exp_strobe;
    exp_strobe = '0;
    if (s.is_req && !s.exp_err) exp_strobe = NO_PORTS'(1) << s.exp_port;
    check_val("port_valid_o", 32'(port_valid_o), 32'(exp_strobe));
    check_val("err_valid_o", 32'(err_valid_o), 32'(s.is_req & s.exp_err));
    if (s.is_req && s.exp_err) begin
      check_val("err_addr_o", err_addr_o, s.addr);
    end else if (s.is_req) begin
      check_val("port_op_o", 32'(port_op_o), 32'(s.op));
      check_val("port_addr_o", port_addr_o, s.addr);
      check_val("port_wdata_o", port_wdata_o, s.data);
    end
  endtask

  // drive at the rising edge, check the previous entry at the falling edge
  task automatic run_step(input step_t s);
    @(posedge clk_i);
    cfg_we_i    <= s.is_cfg;
    cfg_field_i <= s.field;
    cfg_rule_i  <= s.rule;
    cfg_wdata_i <= s.cfg_data;
    req_valid_i <= s.is_req;
    req_op_i    <= s.op;
    req_addr_i  <= s.addr;
    req_wdata_i <= s.data;
    if (s.is_cfg) update_mirror(s);
    @(negedge clk_i);
    check_response(prev_step);
    prev_step = s;
  endtask

  task automatic build_table();
    // empty map, everything is a decode error
    steps.push_back(make_req(OP_READ,  32'h0000_0000, 1'b1, 2'd0));
    steps.push_back(make_req(OP_WRITE, 32'h0000_1000, 1'b1, 2'd0));
    steps.push_back(make_req(OP_READ,  32'hffff_ffff, 1'b1, 2'd0));
    // three disjoint windows
    steps.push_back(make_cfg(FIELD_START, 2'd0, 32'h0000_1000));
    steps.push_back(make_cfg(FIELD_END,   2'd0, 32'h0000_2000));
    steps.push_back(make_cfg(FIELD_PORT,  2'd0, 32'h0000_0001));
    steps.push_back(make_cfg(FIELD_START, 2'd1, 32'h0000_4000));
    steps.push_back(make_cfg(FIELD_END,   2'd1, 32'h0000_5000));
    steps.push_back(make_cfg(FIELD_PORT,  2'd1, 32'h0000_0002));
    steps.push_back(make_cfg(FIELD_START, 2'd2, 32'h8000_0000));
    steps.push_back(make_cfg(FIELD_END,   2'd2, 32'h9000_0000));
    steps.push_back(make_cfg(FIELD_PORT,  2'd2, 32'h0000_0003));
    steps.push_back(make_req(OP_WRITE, 32'h0000_1000, 1'b0, 2'd1));
    steps.push_back(make_req(OP_READ,  32'h0000_1fff, 1'b0, 2'd1));
    steps.push_back(make_req(OP_WRITE, 32'h0000_2000, 1'b1, 2'd0));
    steps.push_back(make_req(OP_READ,  32'h0000_4000, 1'b0, 2'd2));
    steps.push_back(make_req(OP_WRITE, 32'h0000_4fff, 1'b0, 2'd2));
    steps.push_back(make_req(OP_READ,  32'h0000_5000, 1'b1, 2'd0));
    steps.push_back(make_req(OP_WRITE, 32'h8000_0000, 1'b0, 2'd3));
    steps.push_back(make_req(OP_READ,  32'h8fff_ffff, 1'b0, 2'd3));
    steps.push_back(make_req(OP_WRITE, 32'h9000_0000, 1'b1, 2'd0));
    // rule 3 overlaps rules 0 and 1, port data 4 truncates to port 0
    steps.push_back(make_cfg(FIELD_START, 2'd3, 32'h0000_1800));
    steps.push_back(make_cfg(FIELD_END,   2'd3, 32'h0000_4800));
    steps.push_back(make_cfg(FIELD_PORT,  2'd3, 32'h0000_0004));
    steps.push_back(make_req(OP_READ,  32'h0000_1900, 1'b0, 2'd0));
    steps.push_back(make_req(OP_WRITE, 32'h0000_4100, 1'b0, 2'd0));
    steps.push_back(make_req(OP_READ,  32'h0000_17ff, 1'b0, 2'd1));
    steps.push_back(make_req(OP_WRITE, 32'h0000_4800, 1'b0, 2'd2));
    // request right behind a config write sees the new map
    steps.push_back(make_cfg(FIELD_PORT,  2'd3, 32'h0000_0003));
    steps.push_back(make_req(OP_READ,  32'h0000_1900, 1'b0, 2'd3));
    steps.push_back(make_req(OP_WRITE, 32'h0000_1000, 1'b0, 2'd1));
    // default port 2, then disabled again
    steps.push_back(make_cfg(FIELD_DEFAULT, 2'd1, 32'h8000_0002));
    steps.push_back(make_req(OP_READ,  32'h0000_0000, 1'b0, 2'd2));
    steps.push_back(make_req(OP_WRITE, 32'hf000_0000, 1'b0, 2'd2));
    steps.push_back(make_req(OP_READ,  32'h0000_1000, 1'b0, 2'd1));
    steps.push_back(make_cfg(FIELD_DEFAULT, 2'd0, 32'h0000_0002));
    steps.push_back(make_req(OP_WRITE, 32'h0000_0000, 1'b1, 2'd0));
    steps.push_back(make_req(OP_READ,  32'hf000_0000, 1'b1, 2'd0));
  endtask

  initial begin
    arst_n_i    = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_field_i = FIELD_START;
    cfg_rule_i  = '0;
    cfg_wdata_i = '0;
    req_valid_i = 1'b0;
    req_op_i    = OP_READ;
    req_addr_i  = '0;
    req_wdata_i = '0;
    prev_step   = '0;
    for (int i = 0; i < NO_RULES; i++) begin
      mir_start[i] = '0;
      mir_end[i]   = '0;
      mir_port[i]  = '0;
    end
    mir_def_en   = 1'b0;
    mir_def_port = '0;
    build_table();
    // reset, table, random phase with one extra config, drain, margin
    cycle_limit = RESET_CYCLES + steps.size() + RAND_REQS + 2 + 20;

    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;

    foreach (steps[k]) run_step(steps[k]);

    // lfsr addresses, half in the low rule area, half around rule 2
    for (int n = 0; n < RAND_REQS; n++) begin
      if (n == RAND_REQS / 2) run_step(make_cfg(FIELD_DEFAULT, 2'd0, 32'h8000_0001));
      pick_bit   = take_bits(1);
      low_bits   = take_bits(16);
      op_bit     = take_bits(1);
      wdata_bits = take_bits(32);
      if (pick_bit[0]) rnd_addr = {3'b100, low_bits[15:0], 13'h0};
      else rnd_addr = {16'h0, low_bits[15:0]};
      rnd_step        = '0;
      rnd_step.is_req = 1'b1;
      rnd_step.op     = req_op_e'(op_bit[0]);
      rnd_step.addr   = rnd_addr;
      rnd_step.data   = wdata_bits;
      {rnd_step.exp_err, rnd_step.exp_port} = route_model(rnd_addr);
      run_step(rnd_step);
    end

    // idle cycle picks up the last response
    run_step('0);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_xbar_route

/* sources.f */
hdl/addr_map_pkg.sv
hdl/route_pkg.sv
hdl/addr_map_regs.sv
hdl/addr_decode.sv
hdl/req_router.sv
hdl/xbar_route_top.sv
tests/xbar_route_properties.sv
tests/tb_xbar_route.sv

/* run.sh */
#!/bin/sh
# build and run the crossbar routing testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_xbar_route \
  -f sources.f

# a fatal check exits non-zero, the log decides the result
./obj_dir/Vtb_xbar_route > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

if ! grep -qF '*** TEST PASSED ***' sim.log; then
  echo "simulation ended without a pass line"
  exit 1
fi

echo "simulation passed"
